// File: Makefile
# Verilator build and run of the routing node testbench.

VERILATOR ?= verilator
TOP       ?= routing_node_tb
RTL_TOP   ?= routing_node
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMEFLAGS ?= --timing --timescale 1ns/1ps
VFLAGS    ?= --binary $(TIMEFLAGS)
PASS_TEXT ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

lint:
	$(VERILATOR) --lint-only $(TIMEFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(TIMEFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/neighbor_scan.sv
`timescale 1ns/1ps

`include "node_settings.svh"

module neighbor_scan (
	input  logic                clock,
	input  logic                nrst,
	input  logic                start,
	output node_pkg::mem_addr_t mem_address,
	input  node_pkg::word_t     mem_q,
	output node_pkg::word_t     next_sink,
	output node_pkg::word_t     best_hop,
	output logic                done
);

	import node_pkg::*;

	localparam int COUNT_WIDTH = $clog2(`MAX_NEIGHBORS + 1);

	scan_state_t state;
	logic [2:0] step;
	logic [COUNT_WIDTH-1:0] idx;
	logic [COUNT_WIDTH-1:0] count;
	logic [COUNT_WIDTH-1:0] header_count;
	logic sink_found;
	logic hop_found;

	word_t my_cluster;
	word_t my_cost;
	word_t ent_id;
	logic ent_in_cluster;
	logic ent_sink;
	word_t best_cost;

	logic evaluate;
	logic entry_last;
	logic take_sink;
	logic take_hop;

	// ####################################################################
	// Entry evaluation
	// ####################################################################

	// The count word arrives in the last header step, clamped here.
	assign header_count = (mem_q > word_t'(`MAX_NEIGHBORS)) ?
		COUNT_WIDTH'(`MAX_NEIGHBORS) : mem_q[COUNT_WIDTH-1:0];

	// The cost word is on mem_q in step 4 of an entry.
	assign evaluate = (state == scan_entry) && (step == 3'd4);
	assign entry_last = (idx == count - COUNT_WIDTH'(1));

	assign take_sink = evaluate && ent_in_cluster && ent_sink && !sink_found;

	// Strict compare keeps the earliest entry on equal costs.
	assign take_hop = evaluate && ent_in_cluster && !ent_sink && (mem_q < my_cost) &&
		(!hop_found || (mem_q < best_cost));

	always_comb begin
		case (state)
			scan_idle: mem_address = mem_addr_t'(`ADDR_MY_CLUSTER);
			scan_header: begin
				if (step == 3'd0) begin
					mem_address = mem_addr_t'(`ADDR_MY_COST);
				end else begin
					mem_address = mem_addr_t'(`ADDR_NEIGHBOR_COUNT);
				end
			end
			default: begin
				mem_address = mem_addr_t'(`ADDR_TABLE_BASE) +
					mem_addr_t'(idx) * mem_addr_t'(`ENTRY_WORDS) + mem_addr_t'(step);
			end
		endcase
	end

	// ####################################################################
	// Control
	// ####################################################################

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= scan_idle;
			step <= '0;
			idx <= '0;
			done <= 1'b0;
			sink_found <= 1'b0;
			hop_found <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				scan_idle: begin
					if (start) begin
						state <= scan_header;
						step <= '0;
						sink_found <= 1'b0;
						hop_found <= 1'b0;
					end
				end
				scan_header: begin
					step <= step + 3'd1;
					if (step == 3'd2) begin
						step <= '0;
						idx <= '0;
						if (header_count == '0) begin
							done <= 1'b1;
							state <= scan_idle;
						end else begin
							state <= scan_entry;
						end
					end
				end
				default: begin
					step <= step + 3'd1;
					if (take_sink) begin
						sink_found <= 1'b1;
					end
					if (take_hop) begin
						hop_found <= 1'b1;
					end
					if (evaluate) begin
						step <= '0;
						idx <= idx + COUNT_WIDTH'(1);
						if (entry_last) begin
							done <= 1'b1;
							state <= scan_idle;
						end
					end
				end
			endcase
		end
	end

	// ####################################################################
	// Captured words and results
	// ####################################################################

	always_ff @(posedge clock) begin
		if ((state == scan_idle) && start) begin
			next_sink <= word_t'(`NONE_ID);
			best_hop <= word_t'(`NONE_ID);
		end
		if (state == scan_header) begin
			case (step)
				3'd0: my_cluster <= mem_q;
				3'd1: my_cost <= mem_q;
				default: count <= header_count;
			endcase
		end
		if (state == scan_entry) begin
			case (step)
				3'd1: ent_id <= mem_q;
				3'd2: ent_in_cluster <= (mem_q == my_cluster);
				3'd3: ent_sink <= (mem_q != '0);
				default: ;
			endcase
		end
		if (take_sink) begin
			next_sink <= ent_id;
		end
		if (take_hop) begin
			best_hop <= ent_id;
			best_cost <= mem_q;
		end
	end

endmodule

// File: hdl/node_memory.sv
`timescale 1ns/1ps

`include "node_settings.svh"

module node_memory (
	input  logic              clock,
	input  logic              write,
	input  node_pkg::mem_addr_t write_address,
	input  node_pkg::word_t   write_data,
	input  node_pkg::mem_addr_t read_address,
	output node_pkg::word_t   q
);

	import node_pkg::*;

	// ####################################################################
	// Storage
	// ####################################################################

	word_t mem [`MEM_DEPTH];

	// One write port.
	always_ff @(posedge clock) begin
		if (write) begin
			mem[write_address] <= write_data;
		end
	end

	// Registered read port. A read of the address being written returns
	// the old word.
	always_ff @(posedge clock) begin
		q <= mem[read_address];
	end

endmodule

// File: hdl/node_pkg.sv
`include "node_settings.svh"

package node_pkg;

	typedef logic [`WORD_WIDTH-1:0] word_t;
	typedef logic [`ADDR_WIDTH-1:0] mem_addr_t;

	// Neighbor table scanner.
	typedef enum logic [1:0] {
		scan_idle,
		scan_header,
		scan_entry
	} scan_state_t;

	// Action selector, in the order of its normal walk.
	typedef enum logic [2:0] {
		act_wait_start,
		act_check_sink,
		act_check_hop,
		act_end_write,
		act_signal_done,
		act_idle
	} action_state_t;

	// Top level run sequencer.
	typedef enum logic [2:0] {
		seq_idle,
		seq_scanning,
		seq_arm_action,
		seq_acting,
		seq_finished
	} seq_state_t;

endpackage

// File: hdl/routing_node.sv
`timescale 1ns/1ps

`include "node_settings.svh"

module routing_node (
	input  logic                clock,
	input  logic                nrst,
	input  logic                start,
	input  logic                host_wr,
	input  node_pkg::mem_addr_t host_address,
	input  node_pkg::word_t     host_data,
	output node_pkg::word_t     host_q,
	output logic                busy,
	output logic                done,
	output node_pkg::word_t     action,
	output logic                for_aggregation
);

	import node_pkg::*;

	logic scan_start;
	logic scan_done;
	logic act_en;
	logic act_start;
	logic act_wr;
	logic act_done;
	logic mem_write;
	mem_addr_t scan_address;
	mem_addr_t act_address;
	mem_addr_t mem_write_address;
	mem_addr_t mem_read_address;
	word_t act_data;
	word_t mem_write_data;
	word_t mem_q;
	word_t next_sink;
	word_t best_hop;

	// The host and the scanner share the one read port.
	assign host_q = mem_q;

	routing_sequencer u_sequencer (
		.clock            (clock),
		.nrst             (nrst),
		.start            (start),
		.busy             (busy),
		.done             (done),
		.host_wr          (host_wr),
		.host_address     (host_address),
		.host_data        (host_data),
		.scan_start       (scan_start),
		.scan_address     (scan_address),
		.scan_done        (scan_done),
		.act_en           (act_en),
		.act_start        (act_start),
		.act_wr           (act_wr),
		.act_address      (act_address),
		.act_data         (act_data),
		.act_done         (act_done),
		.mem_write        (mem_write),
		.mem_write_address(mem_write_address),
		.mem_write_data   (mem_write_data),
		.mem_read_address (mem_read_address)
	);

	node_memory u_memory (
		.clock        (clock),
		.write        (mem_write),
		.write_address(mem_write_address),
		.write_data   (mem_write_data),
		.read_address (mem_read_address),
		.q            (mem_q)
	);

	neighbor_scan u_scan (
		.clock      (clock),
		.nrst       (nrst),
		.start      (scan_start),
		.mem_address(scan_address),
		.mem_q      (mem_q),
		.next_sink  (next_sink),
		.best_hop   (best_hop),
		.done       (scan_done)
	);

	select_my_action u_select (
		.clock          (clock),
		.nrst           (nrst),
		.en             (act_en),
		.start          (act_start),
		.next_sink      (next_sink),
		.best_hop       (best_hop),
		.address        (act_address),
		.wr_en          (act_wr),
		.data_out       (act_data),
		.action         (action),
		.for_aggregation(for_aggregation),
		.done           (act_done)
	);

endmodule

// File: hdl/routing_sequencer.sv
`timescale 1ns/1ps

`include "node_settings.svh"

module routing_sequencer (
	input  logic                clock,
	input  logic                nrst,
	input  logic                start,
	output logic                busy,
	output logic                done,
	input  logic                host_wr,
	input  node_pkg::mem_addr_t host_address,
	input  node_pkg::word_t     host_data,
	output logic                scan_start,
	input  node_pkg::mem_addr_t scan_address,
	input  logic                scan_done,
	output logic                act_en,
	output logic                act_start,
	input  logic                act_wr,
	input  node_pkg::mem_addr_t act_address,
	input  node_pkg::word_t     act_data,
	input  logic                act_done,
	output logic                mem_write,
	output node_pkg::mem_addr_t mem_write_address,
	output node_pkg::word_t     mem_write_data,
	output node_pkg::mem_addr_t mem_read_address
);

	import node_pkg::*;

	seq_state_t state;
	logic act_done_q;
	logic host_owns;

	// ####################################################################
	// Phase control
	// ####################################################################

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= seq_idle;
			busy <= 1'b0;
			done <= 1'b0;
			scan_start <= 1'b0;
			act_en <= 1'b0;
			act_start <= 1'b0;
			act_done_q <= 1'b0;
		end else begin
			act_done_q <= act_done;
			scan_start <= 1'b0;
			act_en <= 1'b0;
			act_start <= 1'b0;
			case (state)
				seq_scanning: begin
					if (scan_done) begin
						act_en <= 1'b1;
						state <= seq_arm_action;
					end
				end
				seq_arm_action: begin
					act_start <= 1'b1;
					state <= seq_acting;
				end
				seq_acting: begin
					// Selector done is a level; only its rise ends the run.
					if (act_done && !act_done_q) begin
						done <= 1'b1;
						busy <= 1'b0;
						state <= seq_finished;
					end
				end
				default: begin
					if (start) begin
						scan_start <= 1'b1;
						busy <= 1'b1;
						done <= 1'b0;
						state <= seq_scanning;
					end
				end
			endcase
		end
	end

	// ####################################################################
	// Memory port ownership
	// ####################################################################

	assign host_owns = (state == seq_idle) || (state == seq_finished);

	always_comb begin
		mem_write = 1'b0;
		mem_write_address = host_address;
		mem_write_data = host_data;
		if (host_owns) begin
			mem_write = host_wr;
		end else if (state == seq_acting) begin
			mem_write = act_wr;
			mem_write_address = act_address;
			mem_write_data = act_data;
		end
	end

	assign mem_read_address = (state == seq_scanning) ? scan_address : host_address;

endmodule

// File: hdl/select_my_action.sv
`timescale 1ns/1ps

`include "node_settings.svh"

module select_my_action (
	input  logic                clock,
	input  logic                nrst,
	input  logic                en,
	input  logic                start,
	input  node_pkg::word_t     next_sink,
	input  node_pkg::word_t     best_hop,
	output node_pkg::mem_addr_t address,
	output logic                wr_en,
	output node_pkg::word_t     data_out,
	output node_pkg::word_t     action,
	output logic                for_aggregation,
	output logic                done
);

	import node_pkg::*;

	// Possible actions are the best hop, the next sink, or the node itself
	// as cluster head. The exploration hop is not modelled.

	action_state_t state;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= act_idle;
			action <= word_t'(`NONE_ID);
			for_aggregation <= 1'b0;
			wr_en <= 1'b0;
			address <= '0;
			data_out <= '0;
			done <= 1'b0;
		end else begin
			case (state)
				act_wait_start: begin
					if (start) begin
						state <= act_check_sink;
					end
				end
				act_check_sink: begin
					if (next_sink != word_t'(`NONE_ID)) begin
						action <= next_sink;
					end
					state <= act_check_hop;
				end
				act_check_hop: begin
					// No better in-cluster hop, so this node aggregates.
					if (best_hop == word_t'(`NONE_ID)) begin
						for_aggregation <= 1'b1;
						data_out <= word_t'(1);
						address <= mem_addr_t'(`ADDR_AGG_FLAG);
						wr_en <= 1'b1;
					end else begin
						for_aggregation <= 1'b0;
						action <= best_hop;
					end
					state <= act_end_write;
				end
				act_end_write: begin
					wr_en <= 1'b0;
					state <= act_signal_done;
				end
				act_signal_done: begin
					done <= 1'b1;
					state <= act_idle;
				end
				act_idle: begin
					// done holds here until the next enable.
					if (en) begin
						action <= word_t'(`NONE_ID);
						for_aggregation <= 1'b0;
						wr_en <= 1'b0;
						address <= '0;
						data_out <= '0;
						done <= 1'b0;
						state <= act_wait_start;
					end
				end
				default: state <= act_idle;
			endcase
		end
	end

endmodule

// File: include/node_settings.svh
`ifndef NODE_SETTINGS_SVH
`define NODE_SETTINGS_SVH

// ####################################################################
// Data path widths and memory size
// ####################################################################

// A memory word also carries a node identity.
`define WORD_WIDTH 16
`define ADDR_WIDTH 11
`define MEM_DEPTH 2048

// Identity that stands for "no neighbor".
`define NONE_ID 65

// ####################################################################
// Memory map
// ####################################################################

`define ADDR_MY_CLUSTER 0
`define ADDR_MY_COST 1
`define ADDR_AGG_FLAG 2
`define ADDR_NEIGHBOR_COUNT 3

// Neighbor table, one entry per neighbor.
// Entry words in order: neighbor id, cluster id, sink marker, cost.
`define ADDR_TABLE_BASE 16
`define ENTRY_WORDS 4

// Counts above this are clamped by the scanner.
`define MAX_NEIGHBORS 16

`endif

// File: verification/routing_node_tb.sv
`timescale 1ns/1ps

`include "node_settings.svh"

module routing_node_tb;

	import node_pkg::*;

	localparam int CLOCK_PERIOD = 40;
	localparam int DRIVE_DELAY = 2;
	localparam int TABLE_SLOTS = 20;
	localparam int RANDOM_RUNS = 40;
	localparam int RUN_COUNT = RANDOM_RUNS + 4;
	localparam int WATCHDOG_NS =
		2 * RUN_COUNT * (3 + 5 * `MAX_NEIGHBORS + 20) * CLOCK_PERIOD;

	logic clock;
	logic nrst;
	logic start;
	logic host_wr;
	mem_addr_t host_address;
	word_t host_data;
	word_t host_q;
	logic busy;
	logic done;
	word_t action;
	logic for_aggregation;

	// Testbench copy of what is loaded into the node memory.
	word_t my_cluster;
	word_t my_cost;
	word_t count;
	word_t tbl_id [TABLE_SLOTS];
	word_t tbl_cluster [TABLE_SLOTS];
	word_t tbl_sink [TABLE_SLOTS];
	word_t tbl_cost [TABLE_SLOTS];

	word_t exp_action;
	logic exp_agg;
	int errors;
	int checks;
	int seed;

	routing_node DUT (
		.clock          (clock),
		.nrst           (nrst),
		.start          (start),
		.host_wr        (host_wr),
		.host_address   (host_address),
		.host_data      (host_data),
		.host_q         (host_q),
		.busy           (busy),
		.done           (done),
		.action         (action),
		.for_aggregation(for_aggregation)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#(CLOCK_PERIOD / 2);
			clock = ~clock;
		end
	end

	// ####################################################################
	// Helpers
	// ####################################################################

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		errors = errors + 1;
		$display("FAIL at %0t ns: %s is %0d, expected %0d", $time, name, got, want);
	endtask

	function automatic int random_below(input int limit);
		return $unsigned($random(seed)) % limit;
	endfunction

	// All host tasks start and end 2 ns after a rising edge.
	task automatic write_word(input mem_addr_t addr, input word_t value);
		host_wr = 1'b1;
		host_address = addr;
		host_data = value;
		@(posedge clock);
		#DRIVE_DELAY;
		host_wr = 1'b0;
	endtask

	task automatic read_word(input mem_addr_t addr, output word_t value);
		host_address = addr;
		@(posedge clock);
		#DRIVE_DELAY;
		value = host_q;
	endtask

	task automatic set_entry(input int i, input word_t id, input word_t cluster,
		input word_t sink, input word_t cost);
		tbl_id[i] = id;
		tbl_cluster[i] = cluster;
		tbl_sink[i] = sink;
		tbl_cost[i] = cost;
	endtask

	task automatic load_table();
		int i;
		mem_addr_t base;
		write_word(`ADDR_MY_CLUSTER, my_cluster);
		write_word(`ADDR_MY_COST, my_cost);
		write_word(`ADDR_AGG_FLAG, '0);
		write_word(`ADDR_NEIGHBOR_COUNT, count);
		for (i = 0; (i < int'(count)) && (i < TABLE_SLOTS); i++) begin
			base = mem_addr_t'(`ADDR_TABLE_BASE + i * `ENTRY_WORDS);
			write_word(base, tbl_id[i]);
			write_word(base + mem_addr_t'(1), tbl_cluster[i]);
			write_word(base + mem_addr_t'(2), tbl_sink[i]);
			write_word(base + mem_addr_t'(3), tbl_cost[i]);
		end
	endtask

	task automatic randomize_table();
		int i;
		my_cluster = word_t'(random_below(3));
		my_cost = word_t'(random_below(16));
		count = word_t'(random_below(18));
		for (i = 0; i < TABLE_SLOTS; i++) begin
			tbl_id[i] = word_t'(256 + random_below(256));
			tbl_cluster[i] = word_t'(random_below(3));
			tbl_sink[i] = (random_below(5) == 0) ? word_t'(random_below(4) + 1) : '0;
			tbl_cost[i] = word_t'(random_below(16));
		end
	endtask

	// Returns {aggregation flag, action}.
	function automatic logic [`WORD_WIDTH:0] expected_decision();
		int i;
		int limit;
		word_t sink;
		word_t hop;
		word_t hop_cost;
		logic sink_found;
		logic hop_found;
		limit = (count > `MAX_NEIGHBORS) ? `MAX_NEIGHBORS : int'(count);
		sink = `NONE_ID;
		hop = `NONE_ID;
		hop_cost = '0;
		sink_found = 1'b0;
		hop_found = 1'b0;
		for (i = 0; i < limit; i++) begin
			if (tbl_cluster[i] == my_cluster) begin
				if (tbl_sink[i] != '0) begin
					if (!sink_found) begin
						sink = tbl_id[i];
						sink_found = 1'b1;
					end
				end else if ((tbl_cost[i] < my_cost) &&
					(!hop_found || (tbl_cost[i] < hop_cost))) begin
					hop = tbl_id[i];
					hop_cost = tbl_cost[i];
					hop_found = 1'b1;
				end
			end
		end
		return {!hop_found, hop_found ? hop : sink};
	endfunction

	task automatic prepare_expectation();
		logic [`WORD_WIDTH:0] decision;
		decision = expected_decision();
		exp_agg = decision[`WORD_WIDTH];
		exp_action = decision[`WORD_WIDTH-1:0];
	endtask

	task automatic pulse_start();
		start = 1'b1;
		@(posedge clock);
		#DRIVE_DELAY;
		start = 1'b0;
	endtask

	task automatic wait_for_done();
		@(posedge clock);
		#DRIVE_DELAY;
		while (!done) begin
			@(posedge clock);
			#DRIVE_DELAY;
		end
	endtask

	task automatic check_flag_word();
		word_t flag;
		read_word(`ADDR_AGG_FLAG, flag);
		checks++;
		if (flag !== word_t'(exp_agg)) begin
			report_mismatch("agg_flag_word", flag, word_t'(exp_agg));
		end
	endtask

	task automatic run_decision();
		load_table();
		prepare_expectation();
		pulse_start();
		wait_for_done();
		check_flag_word();
	endtask

	// Result check at every rise of done.
	always @(posedge done) begin
		#1;
		checks = checks + 2;
		if (action !== exp_action) begin
			report_mismatch("action", action, exp_action);
		end
		if (for_aggregation !== exp_agg) begin
			report_mismatch("for_aggregation", for_aggregation, exp_agg);
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Finished with errors");
		$finish;
	end

	// ####################################################################
	// Test sequence
	// ####################################################################

	initial begin
		word_t old_value;
		seed = 11;
		errors = 0;
		checks = 0;
		nrst = 1'b0;
		start = 1'b0;
		host_wr = 1'b0;
		host_address = '0;
		host_data = '0;
		exp_action = `NONE_ID;
		exp_agg = 1'b0;
		repeat (5) @(posedge clock);
		#DRIVE_DELAY;
		nrst = 1'b1;

		checks = checks + 4;
		if (busy !== 1'b0) begin
			report_mismatch("busy", busy, 0);
		end
		if (done !== 1'b0) begin
			report_mismatch("done", done, 0);
		end
		if (for_aggregation !== 1'b0) begin
			report_mismatch("for_aggregation", for_aggregation, 0);
		end
		if (action !== word_t'(`NONE_ID)) begin
			report_mismatch("action", action, `NONE_ID);
		end

		// Cheaper in-cluster hop with a tie, plus a sink, while the host
		// tries a second start and a write to entry 4's cost.
		my_cluster = 3;
		my_cost = 50;
		count = 6;
		set_entry(0, 16'h0101, 3, 1, 0);
		set_entry(1, 16'h0102, 4, 0, 10);
		set_entry(2, 16'h0103, 3, 0, 30);
		set_entry(3, 16'h0104, 3, 0, 20);
		set_entry(4, 16'h0105, 3, 0, 20);
		set_entry(5, 16'h0106, 3, 0, 50);
		load_table();
		prepare_expectation();
		pulse_start();
		checks++;
		if (busy !== 1'b1) begin
			report_mismatch("busy", busy, 1);
		end
		write_word(mem_addr_t'(`ADDR_TABLE_BASE + 4 * `ENTRY_WORDS + 3), 16'd1);
		pulse_start();
		wait_for_done();
		check_flag_word();
		read_word(mem_addr_t'(`ADDR_TABLE_BASE + 4 * `ENTRY_WORDS + 3), old_value);
		checks++;
		if (old_value !== 16'd20) begin
			report_mismatch("entry4_cost", old_value, 20);
		end
		repeat (3) @(posedge clock);
		#DRIVE_DELAY;
		checks++;
		if ((done !== 1'b1) || (busy !== 1'b0)) begin
			errors = errors + 1;
			$display("A start pulse given while busy began a second run");
		end

		// In-cluster sink placed after sinks of other clusters.
		my_cluster = 7;
		my_cost = 5;
		count = 6;
		set_entry(0, 16'h0201, 2, 1, 0);
		set_entry(1, 16'h0202, 9, 1, 0);
		set_entry(2, 16'h0203, 7, 0, 5);
		set_entry(3, 16'h0204, 7, 1, 0);
		set_entry(4, 16'h0205, 7, 1, 0);
		set_entry(5, 16'h0206, 7, 0, 9);
		run_decision();

		// Empty table.
		count = 0;
		run_decision();

		// Count of 20; the sink and the cheap hop sit past the clamp.
		my_cluster = 1;
		my_cost = 10;
		count = 20;
		for (int i = 0; i < 16; i++) begin
			set_entry(i, word_t'(16'h0300 + i), word_t'(1 + (i % 2)), 0, word_t'(10 + i));
		end
		set_entry(16, 16'h0310, 1, 1, 0);
		set_entry(17, 16'h0311, 1, 0, 0);
		set_entry(18, 16'h0312, 1, 1, 3);
		set_entry(19, 16'h0313, 1, 0, 2);
		run_decision();

		for (int run = 0; run < RANDOM_RUNS; run++) begin
			randomize_table();
			run_decision();
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
hdl/node_pkg.sv
hdl/node_memory.sv
hdl/neighbor_scan.sv
hdl/select_my_action.sv
hdl/routing_sequencer.sv
hdl/routing_node.sv
verification/routing_node_tb.sv
